/* tests/monitor_patterns.txt */
# op  address(hex)  data(hex)  expected reply(hex)
# W replies K (4b), R replies the stored word, L replies K and sets the leds
W 000000 1234 4b
R 000000 0000 1234
W 400000 abcd 4b
W 000200 5a5a 4b
R 000000 0000 1234
R 400000 0000 abcd
R 000200 0000 5a5a
W ffffff beef 4b
R ffffff 0000 beef
W c01ff3 0f0f 4b
R c01ff3 0000 0f0f
L 000000 005a 4b
L 000000 00a5 4b

/* sim.f */
logic/board_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/sdram_ctrl.sv
logic/uart_monitor.sv
logic/board_main.sv
logic/board_top.sv
tests/tb_board_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_board_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?=

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --top-module $(TOP) --Mdir $(OBJ_DIR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) $(VFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* tests/tb_board_top.sv */
`timescale 1ns/1ps

module tb_board_top;
    import board_pkg::*;

    localparam int RESET_CLKS   = 16;
    localparam int QUIET_CLKS   = 2000;
    localparam int RANDOM_PAIRS = 20;
    localparam int OP_CLKS      = 16;    // Longest memory operation, with margin
    localparam int REFRESH_MAX  = SDRAM_REFRESH_INTERVAL + OP_CLKS;
    localparam int REPLY_WAIT   = 64 * BAUD_DIV;
    localparam byte_t ACK       = "K";

    logic        clk = 1'b0;
    logic        rst_n;
    logic        rx;
    logic        ntrap;
    logic [6:0]  leds;
    logic        tx;
    logic        sdram_clk;
    logic        sdram_cke;
    sdram_row_t  sdram_address;
    sdram_bank_t sdram_ba;
    logic        sdram_ncs;
    logic        sdram_ras;
    logic        sdram_cas;
    logic        sdram_nwe;
    word_t       sdram_data_in = '0;
    word_t       sdram_data_out;
    logic        sdram_data_oe [15:0];
    logic [1:0]  sdram_dqm;

    int unsigned cycle = 0;
    int unsigned lcg_state = 56269;
    int          ops_total = 0;
    logic        init_done = 1'b0;
    byte_t       rx_bytes [$];        // Bytes decoded from tx
    int unsigned ref_times [$];       // Clock of each auto-refresh

    byte_t       pat_op [$];
    mem_addr_t   pat_addr [$];
    word_t       pat_data [$];
    word_t       pat_exp [$];

    board_top dut (
        .clk(clk), .rst_n(rst_n), .ntrap(ntrap), .leds(leds), .tx(tx), .rx(rx),
        .sdram_clk(sdram_clk), .sdram_cke(sdram_cke), .sdram_address(sdram_address),
        .sdram_ba(sdram_ba), .sdram_ncs(sdram_ncs), .sdram_ras(sdram_ras),
        .sdram_cas(sdram_cas), .sdram_nwe(sdram_nwe), .sdram_data_in(sdram_data_in),
        .sdram_data_out(sdram_data_out), .sdram_data_oe(sdram_data_oe),
        .sdram_dqm(sdram_dqm)
    );

    initial begin : clock_gen
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual)
            abort_run($sformatf("ERR %s: expected %h, actual %h", name, expected, actual));
    endtask

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Largest refresh spacing from from_cycle up to the current clock
    function automatic int unsigned refresh_gap_max(int unsigned from_cycle);
        int unsigned gap;
        gap = 0;
        for (int i = 1; i < ref_times.size(); i++) begin
            if (ref_times[i] >= from_cycle && ref_times[i] - ref_times[i-1] > gap)
                gap = ref_times[i] - ref_times[i-1];
        end
        if (ref_times.size() > 0 && cycle - ref_times[$] > gap)
            gap = cycle - ref_times[$];
        return gap;
    endfunction

    function automatic int refresh_count_since(int unsigned from_cycle);
        int n;
        n = 0;
        foreach (ref_times[i])
            if (ref_times[i] >= from_cycle)
                n++;
        return n;
    endfunction

    // Per-pin data enables as one vector
    function automatic logic [15:0] data_oe_bits();
        logic [15:0] bits;
        for (int i = 0; i < 16; i++)
            bits[i] = sdram_data_oe[i];
        return bits;
    endfunction

    ////////////////////////////////////////////////////////////
    // UART host side

    task automatic send_byte(byte_t b);
        @(negedge clk);
        rx = 1'b0;
        repeat (BAUD_DIV) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            rx = b[i];                        // LSB first
            repeat (BAUD_DIV) @(negedge clk);
        end
        rx = 1'b1;
        repeat (BAUD_DIV) @(negedge clk);
    endtask

    task automatic receive_byte(output byte_t b);
        int waited;
        waited = 0;
        while (rx_bytes.size() == 0 && waited < REPLY_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (rx_bytes.size() == 0)
            abort_run("No reply byte came back from the DUT in time");
        else
            b = rx_bytes.pop_front();
    endtask

    task automatic send_addr(mem_addr_t a);
        send_byte(a[23:16]);
        send_byte(a[15:8]);
        send_byte(a[7:0]);
    endtask

    task automatic run_write(mem_addr_t a, word_t d, byte_t exp, string name);
        byte_t r;
        send_byte("W");
        send_addr(a);
        send_byte(d[15:8]);
        send_byte(d[7:0]);
        receive_byte(r);
        check_value(name, 32'(exp), 32'(r));
    endtask

    task automatic run_read(mem_addr_t a, word_t exp, string name);
        byte_t hi;
        byte_t lo;
        send_byte("R");
        send_addr(a);
        receive_byte(hi);
        receive_byte(lo);
        check_value(name, 32'(exp), 32'({hi, lo}));
    endtask

    task automatic run_led(byte_t v, byte_t exp, string name);
        byte_t      r;
        logic [6:0] want;
        want = ~v[6:0];
        send_byte("L");
        send_byte(v);
        receive_byte(r);
        check_value(name, 32'(exp), 32'(r));
        check_value({name, " leds"}, 32'(want), 32'(leds));
    endtask

    initial begin : tx_decoder
        byte_t value;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            if (tx === 1'b0) begin
                repeat (BAUD_DIV / 2) @(negedge clk);   // Middle of start bit
                if (tx !== 1'b0)
                    abort_run("Start bit on tx was shorter than half a bit time");
                for (int i = 0; i < 8; i++) begin
                    repeat (BAUD_DIV) @(negedge clk);
                    value[i] = tx;
                end
                repeat (BAUD_DIV) @(negedge clk);
                if (tx !== 1'b1)
                    abort_run("Stop bit on tx was low");
                rx_bytes.push_back(value);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // SDRAM model, commands sampled on the SDRAM clock

    word_t      sdram_mem [mem_addr_t];
    sdram_row_t open_row [4];
    word_t      rd_word;
    int         rd_delay = 0;

    always @(posedge sdram_clk) begin : sdram_model
        mem_addr_t   wa;
        logic        is_write;
        if (rst_n === 1'b1) begin
            if (rd_delay > 0) begin
                rd_delay--;
                if (rd_delay == 0)
                    sdram_data_in <= rd_word;
            end
            check_value("sdram clock phase", 32'd0, 32'(clk));   // Inverted system clock
            check_value("dqm", 32'd0, 32'(sdram_dqm));
            is_write = !sdram_ncs && sdram_ras && !sdram_cas && !sdram_nwe;
            check_value("data output enable", is_write ? 32'hffff : 32'h0,
                        32'(data_oe_bits()));
            wa = {sdram_ba, open_row[sdram_ba], sdram_address[8:0]};
            if (!sdram_ncs) begin
                case ({sdram_ras, sdram_cas, sdram_nwe})
                    3'b011: open_row[sdram_ba] = sdram_address;   // Activate
                    3'b101: begin
                        check_value("read auto-precharge", 32'd1, 32'(sdram_address[10]));
                        rd_word  = sdram_mem.exists(wa) ? sdram_mem[wa] : 16'h0000;
                        rd_delay = SDRAM_CAS_LATENCY;
                    end
                    3'b100: begin
                        check_value("write auto-precharge", 32'd1, 32'(sdram_address[10]));
                        sdram_mem[wa] = sdram_data_out;
                    end
                    3'b001: ref_times.push_back(cycle);
                    3'b000: init_done = 1'b1;                     // Mode load ends init
                    default: ;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Test sequence

    initial begin : watchdog
        wait (ops_total != 0);
        repeat (ops_total * 64 * BAUD_DIV + RESET_CLKS + SDRAM_INIT_WAIT + QUIET_CLKS)
            @(posedge clk);
        abort_run("Watchdog timeout, the run did not finish in time");
    end

    initial begin : main
        int          fd;
        int          n;
        string       line;
        byte_t       op;
        logic [23:0] pa;
        logic [15:0] pd;
        logic [15:0] pe;
        int unsigned r;
        int unsigned quiet_start;
        mem_addr_t   addr;
        word_t       data;
        rx    = 1'b1;
        rst_n = 1'b0;

        fd = $fopen("tests/monitor_patterns.txt", "r");
        if (fd == 0)
            abort_run("Cannot open tests/monitor_patterns.txt");
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line[0] == "#")
                continue;
            n = $sscanf(line, "%c %h %h %h", op, pa, pd, pe);
            if (n != 4)
                abort_run($sformatf("Malformed pattern line: %s", line));
            pat_op.push_back(op);
            pat_addr.push_back(pa);
            pat_data.push_back(pd);
            pat_exp.push_back(pe);
        end
        $fclose(fd);
        ops_total = pat_op.size() + 2 * RANDOM_PAIRS + 3;

        repeat (8) @(negedge clk);
        check_value("reset ntrap", 32'd1, 32'(ntrap));
        check_value("reset tx", 32'd1, 32'(tx));
        check_value("reset ncs", 32'd1, 32'(sdram_ncs));
        check_value("reset cke", 32'd1, 32'(sdram_cke));
        check_value("reset data enable", 32'h0, 32'(data_oe_bits()));
        repeat (RESET_CLKS - 8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("leds after reset", 32'h7f, 32'(leds));

        // Idle bus, only refresh traffic
        wait (init_done);
        @(negedge clk);
        quiet_start = cycle;
        repeat (QUIET_CLKS) @(negedge clk);
        if (refresh_gap_max(quiet_start) > REFRESH_MAX)
            abort_run("Auto-refreshes too far apart while the bus was quiet");
        if (refresh_count_since(quiet_start) < QUIET_CLKS / REFRESH_MAX)
            abort_run("Too few auto-refreshes while the bus was quiet");

        foreach (pat_op[i]) begin
            case (pat_op[i])
                "W": run_write(pat_addr[i], pat_data[i], byte_t'(pat_exp[i]),
                               $sformatf("pattern %0d W", i));
                "R": run_read(pat_addr[i], pat_exp[i], $sformatf("pattern %0d R", i));
                "L": run_led(byte_t'(pat_data[i]), byte_t'(pat_exp[i]),
                             $sformatf("pattern %0d L", i));
                default: abort_run($sformatf("Unknown operation in pattern %0d", i));
            endcase
        end

        for (int i = 0; i < RANDOM_PAIRS; i++) begin
            r    = next_random();
            addr = {i[1:0], r[29:8]};            // Walk all four banks
            r    = next_random();
            data = r[31:16];
            run_write(addr, data, ACK, $sformatf("random write %0d", i));
            run_read(addr, data, $sformatf("random read %0d", i));
        end

        check_value("ntrap before bad command", 32'd1, 32'(ntrap));
        send_byte("X");
        repeat (20 * BAUD_DIV) @(negedge clk);
        check_value("reply bytes to bad command", 32'd0, 32'(rx_bytes.size()));
        check_value("ntrap after bad command", 32'd0, 32'(ntrap));
        run_led(8'h3c, ACK, "led after trap");
        check_value("ntrap held low", 32'd0, 32'(ntrap));

        if (refresh_gap_max(quiet_start) > REFRESH_MAX)
            abort_run("Auto-refreshes too far apart during memory traffic");
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* logic/board_top.sv */
`timescale 1ns/1ps

module board_top (
    input  logic                   clk,
    input  logic                   rst_n,
    output logic                   ntrap,
    output logic [6:0]             leds,
    output logic                   tx,
    input  logic                   rx,
    output logic                   sdram_clk,
    output logic                   sdram_cke,
    output board_pkg::sdram_row_t  sdram_address,
    output board_pkg::sdram_bank_t sdram_ba,
    output logic                   sdram_ncs,
    output logic                   sdram_ras,
    output logic                   sdram_cas,
    output logic                   sdram_nwe,
    input  board_pkg::word_t       sdram_data_in,
    output board_pkg::word_t       sdram_data_out,
    output logic                   sdram_data_oe [15:0],
    output logic [1:0]             sdram_dqm
);
    import board_pkg::*;

    byte_t main_leds;
    logic  sdram_data_noe;

    assign leds = ~main_leds[6:0];   // LEDs are active low

    // One enable per data pin
    for (genvar i = 0; i < 16; i++) begin : g_data_oe
        assign sdram_data_oe[i] = !sdram_data_noe;
    end

    board_main m (
        .clk(clk), .rst_n(rst_n), .rx(rx), .tx(tx), .ntrap(ntrap), .leds(main_leds),
        .sdram_clk(sdram_clk), .sdram_cke(sdram_cke), .sdram_ras(sdram_ras),
        .sdram_cas(sdram_cas), .sdram_nwe(sdram_nwe), .sdram_ncs(sdram_ncs),
        .sdram_data_noe(sdram_data_noe), .sdram_address(sdram_address),
        .sdram_ba(sdram_ba), .sdram_data_out(sdram_data_out), .sdram_dqm(sdram_dqm),
        .sdram_data_in(sdram_data_in)
    );

endmodule

/* logic/board_main.sv */
`timescale 1ns/1ps

module board_main (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   rx,
    output logic                   tx,
    output logic                   ntrap,
    output board_pkg::byte_t       leds,
    output logic                   sdram_clk,
    output logic                   sdram_cke,
    output logic                   sdram_ras,
    output logic                   sdram_cas,
    output logic                   sdram_nwe,
    output logic                   sdram_ncs,
    output logic                   sdram_data_noe,
    output board_pkg::sdram_row_t  sdram_address,
    output board_pkg::sdram_bank_t sdram_ba,
    output board_pkg::word_t       sdram_data_out,
    output logic [1:0]             sdram_dqm,
    input  board_pkg::word_t       sdram_data_in
);
    import board_pkg::*;

    byte_t     rx_data;
    byte_t     tx_data;
    logic      rx_valid;
    logic      tx_start;
    logic      tx_busy;
    logic      mem_req;
    logic      mem_we;
    logic      mem_done;
    mem_addr_t mem_addr;
    word_t     mem_wdata;
    word_t     mem_rdata;
    logic      bad_cmd;

    assign sdram_clk = ~clk;   // SDRAM samples mid-cycle

    // Trap stays set until reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ntrap <= 1'b1;
        else if (bad_cmd)
            ntrap <= 1'b0;
    end

    uart_rx u_rx (
        .clk(clk), .rst_n(rst_n), .rx(rx), .rx_data(rx_data), .rx_valid(rx_valid)
    );

    uart_tx u_tx (
        .clk(clk), .rst_n(rst_n), .tx_start(tx_start), .tx_data(tx_data),
        .tx(tx), .tx_busy(tx_busy)
    );

    uart_monitor u_monitor (
        .clk(clk), .rst_n(rst_n), .rx_valid(rx_valid), .rx_data(rx_data),
        .tx_busy(tx_busy), .tx_start(tx_start), .tx_data(tx_data),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_done(mem_done), .mem_rdata(mem_rdata), .led_value(leds), .bad_cmd(bad_cmd)
    );

    sdram_ctrl u_sdram (
        .clk(clk), .rst_n(rst_n), .mem_req(mem_req), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_done(mem_done),
        .mem_rdata(mem_rdata), .sdram_cke(sdram_cke), .sdram_ncs(sdram_ncs),
        .sdram_ras(sdram_ras), .sdram_cas(sdram_cas), .sdram_nwe(sdram_nwe),
        .sdram_data_noe(sdram_data_noe), .sdram_address(sdram_address),
        .sdram_ba(sdram_ba), .sdram_data_out(sdram_data_out),
        .sdram_data_in(sdram_data_in), .sdram_dqm(sdram_dqm)
    );

endmodule

/* logic/uart_monitor.sv */
`timescale 1ns/1ps

module uart_monitor (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rx_valid,
    input  board_pkg::byte_t     rx_data,
    input  logic                 tx_busy,
    output logic                 tx_start,
    output board_pkg::byte_t     tx_data,
    output logic                 mem_req,
    output logic                 mem_we,
    output board_pkg::mem_addr_t mem_addr,
    output board_pkg::word_t     mem_wdata,
    input  logic                 mem_done,
    input  board_pkg::word_t     mem_rdata,
    output board_pkg::byte_t     led_value,
    output logic                 bad_cmd
);
    import board_pkg::*;

    monitor_state_t state;
    byte_t          cmd;
    byte_t          reply_lo;  // Second byte of a read reply
    logic [1:0]     count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= MON_CMD;
            cmd       <= '0;
            reply_lo  <= '0;
            count     <= '0;
            tx_start  <= 1'b0;
            tx_data   <= '0;
            mem_req   <= 1'b0;
            mem_we    <= 1'b0;
            mem_addr  <= '0;
            mem_wdata <= '0;
            led_value <= '0;
            bad_cmd   <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            mem_req  <= 1'b0;
            bad_cmd  <= 1'b0;
            case (state)
                MON_CMD: begin
                    if (rx_valid && !tx_busy) begin
                        cmd   <= rx_data;
                        count <= '0;
                        case (rx_data)
                            "W", "R": state <= MON_ADDR;
                            "L":      state <= MON_DATA;
                            default:  bad_cmd <= 1'b1;
                        endcase
                    end
                end
                MON_ADDR: begin
                    if (rx_valid) begin
                        mem_addr <= {mem_addr[15:0], rx_data};  // High byte first
                        count    <= count + 1'b1;
                        if (count == 2'd2) begin
                            count <= '0;
                            if (cmd == "W") begin
                                state <= MON_DATA;
                            end else begin
                                mem_req <= 1'b1;
                                mem_we  <= 1'b0;
                                state   <= MON_MEM_WAIT;
                            end
                        end
                    end
                end
                MON_DATA: begin
                    if (rx_valid) begin
                        count <= count + 1'b1;
                        if (cmd == "L") begin
                            led_value <= rx_data;
                            tx_start  <= 1'b1;
                            tx_data   <= "K";
                            state     <= MON_CMD;
                        end else begin
                            mem_wdata <= {mem_wdata[7:0], rx_data};
                            if (count == 2'd1) begin
                                mem_req <= 1'b1;
                                mem_we  <= 1'b1;
                                state   <= MON_MEM_WAIT;
                            end
                        end
                    end
                end
                MON_MEM_WAIT: begin
                    if (mem_done) begin
                        tx_start <= 1'b1;
                        if (mem_we) begin
                            tx_data <= "K";
                            state   <= MON_CMD;
                        end else begin
                            tx_data  <= mem_rdata[15:8];
                            reply_lo <= mem_rdata[7:0];
                            state    <= MON_REPLY;
                        end
                    end
                end
                MON_REPLY: begin
                    if (!tx_busy && !tx_start) begin   // Busy rises a clock after start
                        tx_start <= 1'b1;
                        tx_data  <= reply_lo;
                        state    <= MON_CMD;
                    end
                end
                default: state <= MON_CMD;
            endcase
        end
    end

endmodule

/* logic/sdram_ctrl.sv */
`timescale 1ns/1ps

module sdram_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   mem_req,
    input  logic                   mem_we,
    input  board_pkg::mem_addr_t   mem_addr,
    input  board_pkg::word_t       mem_wdata,
    output logic                   mem_done,
    output board_pkg::word_t       mem_rdata,
    output logic                   sdram_cke,
    output logic                   sdram_ncs,
    output logic                   sdram_ras,
    output logic                   sdram_cas,
    output logic                   sdram_nwe,
    output logic                   sdram_data_noe,
    output board_pkg::sdram_row_t  sdram_address,
    output board_pkg::sdram_bank_t sdram_ba,
    output board_pkg::word_t       sdram_data_out,
    input  board_pkg::word_t       sdram_data_in,
    output logic [1:0]             sdram_dqm
);
    import board_pkg::*;

    sdram_state_t state;
    sdram_state_t after_wait;   // Where ST_WAIT goes when the delay runs out
    delay_t       delay;
    refresh_cnt_t refresh_cnt;
    logic         refresh_due;
    logic         req_pending;
    logic         done_pending;
    logic [1:0]   init_refs;    // Refreshes left in power-up
    logic         op_we;
    mem_addr_t    op_addr;
    word_t        op_wdata;
    logic         start_op;
    logic         finish_op;
    sdram_row_t   col_address;

    assign start_op  = state == ST_IDLE && !refresh_due && req_pending;
    assign finish_op = state == ST_WAIT && delay == '0 && done_pending;
    assign col_address = {3'b001, 1'b0, op_addr[8:0]};  // A10 selects auto-precharge

    assign sdram_cke      = 1'b1;
    assign sdram_dqm      = 2'b00;
    assign sdram_data_out = op_wdata;

    ////////////////////////////////////////////////////////////
    // Sequencer

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_INIT_WAIT;
            after_wait   <= ST_IDLE;
            delay        <= delay_t'(SDRAM_INIT_WAIT - 1);
            init_refs    <= 2'd2;
            req_pending  <= 1'b0;
            done_pending <= 1'b0;
            mem_done     <= 1'b0;
        end else begin
            mem_done <= 1'b0;
            if (mem_req)
                req_pending <= 1'b1;
            case (state)
                ST_INIT_WAIT: begin
                    if (delay == '0)
                        state <= ST_PRECHARGE_ALL;
                    else
                        delay <= delay - 1'b1;
                end
                ST_PRECHARGE_ALL: begin
                    state      <= ST_WAIT;
                    after_wait <= ST_REFRESH;
                    delay      <= delay_t'(SDRAM_PRECHARGE_LATENCY - 2);
                end
                ST_REFRESH: begin
                    state <= ST_WAIT;
                    delay <= delay_t'(SDRAM_AUTOREFRESH_LATENCY - 2);
                    if (init_refs == 2'd2)
                        after_wait <= ST_REFRESH;
                    else if (init_refs == 2'd1)
                        after_wait <= ST_LOAD_MODE;
                    else
                        after_wait <= ST_IDLE;
                    if (init_refs != 2'd0)
                        init_refs <= init_refs - 1'b1;
                end
                ST_LOAD_MODE: begin
                    state      <= ST_WAIT;
                    after_wait <= ST_IDLE;
                    delay      <= '0;           // tMRD of two clocks
                end
                ST_IDLE: begin
                    if (refresh_due) begin
                        state <= ST_REFRESH;
                    end else if (req_pending) begin
                        req_pending <= 1'b0;
                        state       <= ST_ACTIVATE;
                    end
                end
                ST_ACTIVATE: begin
                    state      <= ST_WAIT;
                    after_wait <= op_we ? ST_WRITE : ST_READ;
                    delay      <= delay_t'(SDRAM_BANK_ACTIVATE_LATENCY - 2);
                end
                ST_WRITE: begin
                    state        <= ST_WAIT;
                    after_wait   <= ST_IDLE;
                    delay        <= delay_t'(SDRAM_PRECHARGE_LATENCY - 2);
                    done_pending <= 1'b1;
                end
                ST_READ: begin
                    state        <= ST_WAIT;
                    after_wait   <= ST_IDLE;
                    delay        <= delay_t'(SDRAM_CAS_LATENCY); // One extra clock to capture
                    done_pending <= 1'b1;
                end
                ST_WAIT: begin
                    if (delay != '0) begin
                        delay <= delay - 1'b1;
                    end else if (done_pending) begin
                        done_pending <= 1'b0;
                        mem_done     <= 1'b1;
                        if (op_we)
                            state <= after_wait;
                        else
                            delay <= delay_t'(SDRAM_PRECHARGE_LATENCY - 1); // Let precharge finish
                    end else begin
                        state <= after_wait;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Request payload and read data
    always_ff @(posedge clk) begin
        if (start_op) begin
            op_we    <= mem_we;
            op_addr  <= mem_addr;
            op_wdata <= mem_wdata;
        end
        if (finish_op && !op_we)
            mem_rdata <= sdram_data_in;
    end

    // Refresh interval timer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            refresh_cnt <= refresh_cnt_t'(SDRAM_REFRESH_INTERVAL - 1);
            refresh_due <= 1'b0;
        end else if (refresh_cnt == '0) begin
            refresh_cnt <= refresh_cnt_t'(SDRAM_REFRESH_INTERVAL - 1);
            refresh_due <= 1'b1;
        end else begin
            refresh_cnt <= refresh_cnt - 1'b1;
            if (state == ST_REFRESH)
                refresh_due <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Command decode

    always_comb begin
        sdram_ncs      = 1'b0;
        sdram_ras      = 1'b1;
        sdram_cas      = 1'b1;
        sdram_nwe      = 1'b1;
        sdram_data_noe = 1'b1;
        sdram_address  = op_addr[21:9];
        sdram_ba       = op_addr[23:22];
        case (state)
            ST_INIT_WAIT: sdram_ncs = 1'b1;
            ST_PRECHARGE_ALL: begin
                sdram_ras     = 1'b0;
                sdram_nwe     = 1'b0;
                sdram_address = 13'h0400;   // All banks
            end
            ST_REFRESH: begin
                sdram_ras = 1'b0;
                sdram_cas = 1'b0;
            end
            ST_LOAD_MODE: begin
                sdram_ras     = 1'b0;
                sdram_cas     = 1'b0;
                sdram_nwe     = 1'b0;
                sdram_address = SDRAM_MODE_REGISTER_VALUE;
            end
            ST_ACTIVATE: sdram_ras = 1'b0;
            ST_READ: begin
                sdram_cas     = 1'b0;
                sdram_address = col_address;
            end
            ST_WRITE: begin
                sdram_cas      = 1'b0;
                sdram_nwe      = 1'b0;
                sdram_address  = col_address;
                sdram_data_noe = 1'b0;
            end
            default: ;   // NOP
        endcase
    end

endmodule

/* logic/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             tx_start,
    input  board_pkg::byte_t tx_data,
    output logic             tx,
    output logic             tx_busy
);
    import board_pkg::*;

    baud_cnt_t  cnt;
    logic [3:0] bit_idx;
    logic [8:0] shifter;   // Data bits then stop bit

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx      <= 1'b1;
            tx_busy <= 1'b0;
            cnt     <= '0;
            bit_idx <= '0;
            shifter <= '1;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx      <= 1'b0;                  // Start bit
                tx_busy <= 1'b1;
                shifter <= {1'b1, tx_data};
                cnt     <= baud_cnt_t'(BAUD_DIV - 1);
                bit_idx <= '0;
            end
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end else begin
            cnt <= baud_cnt_t'(BAUD_DIV - 1);
            if (bit_idx == 4'd9) begin
                tx_busy <= 1'b0;                  // Stop bit done
            end else begin
                tx      <= shifter[0];
                shifter <= {1'b1, shifter[8:1]};
                bit_idx <= bit_idx + 1'b1;
            end
        end
    end

endmodule

/* logic/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             rx,
    output board_pkg::byte_t rx_data,
    output logic             rx_valid
);
    import board_pkg::*;

    logic      rx_meta;
    logic      rx_sync;
    logic      busy;
    baud_cnt_t cnt;
    logic [3:0] bit_idx;   // 0 start, 1..8 data, 9 stop
    byte_t     shifter;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta  <= 1'b1;
            rx_sync  <= 1'b1;
            busy     <= 1'b0;
            cnt      <= '0;
            bit_idx  <= '0;
            shifter  <= '0;
            rx_data  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_meta  <= rx;
            rx_sync  <= rx_meta;
            rx_valid <= 1'b0;
            if (!busy) begin
                if (!rx_sync) begin
                    busy    <= 1'b1;
                    cnt     <= baud_cnt_t'(BAUD_DIV / 2 - 1); // Land on mid start bit
                    bit_idx <= '0;
                end
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end else begin
                cnt     <= baud_cnt_t'(BAUD_DIV - 1);
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == 4'd0) begin
                    if (rx_sync)
                        busy <= 1'b0;             // Glitch, not a start bit
                end else if (bit_idx == 4'd9) begin
                    busy <= 1'b0;
                    if (rx_sync) begin            // Bad stop bit drops the frame
                        rx_data  <= shifter;
                        rx_valid <= 1'b1;
                    end
                end else begin
                    shifter <= {rx_sync, shifter[7:1]}; // LSB first
                end
            end
        end
    end

endmodule

/* logic/board_pkg.sv */
package board_pkg;

    localparam int CLK_FREQUENCY = 25_000_000;
    localparam int UART_BAUD     = 1_562_500;
    localparam int BAUD_DIV      = CLK_FREQUENCY / UART_BAUD; // Clocks per serial bit

    ////////////////////////////////////////////////////////////
    // SDRAM timing, in system clocks

    localparam int SDRAM_CAS_LATENCY           = 2;
    localparam int SDRAM_BANK_ACTIVATE_LATENCY = 2;
    localparam int SDRAM_PRECHARGE_LATENCY     = 2;
    localparam int SDRAM_AUTOREFRESH_LATENCY   = 3;
    localparam int SDRAM_INIT_WAIT             = 200;
    localparam int SDRAM_REFRESH_INTERVAL      = 390;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;
    typedef logic [23:0] mem_addr_t;   // Bank, row, column
    typedef logic [12:0] sdram_row_t;
    typedef logic [1:0]  sdram_bank_t;

    typedef logic [$clog2(BAUD_DIV)-1:0]               baud_cnt_t;
    typedef logic [$clog2(SDRAM_INIT_WAIT)-1:0]        delay_t;
    typedef logic [$clog2(SDRAM_REFRESH_INTERVAL)-1:0] refresh_cnt_t;

    // Burst length 1, sequential, CAS latency 2
    localparam sdram_row_t SDRAM_MODE_REGISTER_VALUE = 13'h020;

    typedef enum logic [3:0] {
        ST_INIT_WAIT,
        ST_PRECHARGE_ALL,
        ST_REFRESH,
        ST_LOAD_MODE,
        ST_IDLE,
        ST_ACTIVATE,
        ST_READ,
        ST_WRITE,
        ST_WAIT
    } sdram_state_t;

    typedef enum logic [2:0] {
        MON_CMD,
        MON_ADDR,
        MON_DATA,
        MON_MEM_WAIT,
        MON_REPLY
    } monitor_state_t;

endpackage
